// File: src/dl11_macros.svh
//====================
// register addresses, interrupt vectors and baud divisor for the DL11 console
// include in any file that decodes the I/O page or paces the serial line
//====================
`ifndef DL11_MACROS_SVH
`define DL11_MACROS_SVH

// I/O page word addresses
`define DL11_RCSR_ADDR 13'o17560
`define DL11_RBUF_ADDR 13'o17562
`define DL11_XCSR_ADDR 13'o17564
`define DL11_XBUF_ADDR 13'o17566

// interrupt vectors, receive has priority
`define DL11_RX_VECTOR 8'o60
`define DL11_TX_VECTOR 8'o64

// clk cycles per 16x oversample tick, 4 gives 64 clocks per bit
`define DL11_BAUD_DIV 4

// status register bit positions
`define DL11_DONE_BIT 7
`define DL11_IE_BIT 6

`endif

// File: src/dl11_pkg.sv
//====================
// shared types of the DL11 console
// bus request, received character and interrupt request
//====================
package dl11_pkg;

   // one I/O page bus cycle from the CPU
   typedef struct packed {
      logic [12:0] addr;
      logic [15:0] wdata;
      logic        rd;
      logic        wr;
   } iopage_req_t;

   // character from the receiver, valid pulses for one clock
   typedef struct packed {
      logic [7:0] data;
      logic       valid;
   } rx_char_t;

   // interrupt request with its vector, zero vector when idle
   typedef struct packed {
      logic       req;
      logic [7:0] vector;
   } intr_t;

endpackage

// File: src/dl11_baud_gen.sv
//====================
// clock-enable ticks for the serial line
// sample_tick is the 16x oversample rate, bit_tick the bit rate
//====================
`timescale 1ns/10ps
`include "dl11_macros.svh"

module dl11_baud_gen
(
   input  logic clk,
   input  logic reset,
   output logic sample_tick,
   output logic bit_tick
);

   localparam int DIV_W = (`DL11_BAUD_DIV > 1) ? $clog2(`DL11_BAUD_DIV) : 1;

   logic [DIV_W-1:0] div_cnt;
   logic [3:0]       smp_cnt;

   assign sample_tick = (div_cnt == DIV_W'(`DL11_BAUD_DIV - 1));
   // one bit is 16 oversample ticks
   assign bit_tick = sample_tick && (smp_cnt == 4'd15);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         div_cnt <= '0;
         smp_cnt <= '0;
      end
      else
      begin
         if (sample_tick)
         begin
            div_cnt <= '0;
            smp_cnt <= smp_cnt + 4'd1;
         end
         else
         begin
            div_cnt <= div_cnt + DIV_W'(1);
         end
      end
   end

   // the sample tick before a bit tick lies one divide period back
   a_tick_spacing: assert property (@(posedge clk) disable iff (reset)
      bit_tick |-> $past(sample_tick, `DL11_BAUD_DIV));

endmodule

// File: src/dl11_uart_tx.sv
//====================
// 8N1 serializer, one bit per bit_tick, LSB first
// takes a character while tx_load is high and the transmitter is empty
//====================
`timescale 1ns/10ps

module dl11_uart_tx
(
   input  logic       clk,
   input  logic       reset,
   input  logic       bit_tick,
   input  logic       tx_load,
   input  logic [7:0] tx_data,
   output logic       tx,
   output logic       tx_empty
);

   logic [9:0] shift;
   logic [3:0] bit_cnt;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         tx       <= 1'b1;
         tx_empty <= 1'b1;
         bit_cnt  <= '0;
      end
      else if (tx_empty)
      begin
         if (tx_load)
         begin
            tx_empty <= 1'b0;
            bit_cnt  <= '0;
         end
      end
      else if (bit_tick)
      begin
         // the stop bit has had its full bit time once ten bits are out
         if (bit_cnt == 4'd10)
         begin
            tx_empty <= 1'b1;
         end
         else
         begin
            tx      <= shift[0];
            bit_cnt <= bit_cnt + 4'd1;
         end
      end
   end

   // frame is stop, data, start from msb to lsb
   always_ff @(posedge clk)
   begin
      if (tx_empty && tx_load)
      begin
         shift <= {1'b1, tx_data, 1'b0};
      end
      else if (!tx_empty && bit_tick && bit_cnt != 4'd10)
      begin
         shift <= {1'b1, shift[9:1]};
      end
   end

   a_idle_high: assert property (@(posedge clk) disable iff (reset)
      tx_empty |-> tx);

endmodule

// File: src/dl11_uart_rx.sv
//====================
// 8N1 deserializer sampled on the 16x tick
// start bit is confirmed at mid-bit, frames with a low stop bit are dropped
//====================
`timescale 1ns/10ps

module dl11_uart_rx
(
   input  logic              clk,
   input  logic              reset,
   input  logic              sample_tick,
   input  logic              rx,
   output dl11_pkg::rx_char_t rx_char
);

   typedef enum logic [1:0]
   {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   rx_state_t  state;
   logic       rx_meta;
   logic       rx_sync;
   logic [3:0] tick_cnt;
   logic [2:0] bit_idx;
   logic [7:0] rx_shift;
   logic       rx_valid;

   assign rx_char = '{data: rx_shift, valid: rx_valid};

   // two-stage synchronizer, idles high
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end
      else
      begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= RX_IDLE;
         tick_cnt <= '0;
         bit_idx  <= '0;
         rx_valid <= 1'b0;
      end
      else
      begin
         rx_valid <= 1'b0;
         if (sample_tick)
         begin
            tick_cnt <= tick_cnt + 4'd1;
            case (state)
               RX_IDLE:
               begin
                  if (!rx_sync)
                  begin
                     state    <= RX_START;
                     tick_cnt <= '0;
                  end
               end
               RX_START:
               begin
                  // mid start bit, a glitch returns to idle
                  if (tick_cnt == 4'd7)
                  begin
                     state    <= rx_sync ? RX_IDLE : RX_DATA;
                     tick_cnt <= '0;
                     bit_idx  <= '0;
                  end
               end
               RX_DATA:
               begin
                  if (tick_cnt == 4'd15)
                  begin
                     bit_idx <= bit_idx + 3'd1;
                     if (bit_idx == 3'd7)
                     begin
                        state <= RX_STOP;
                     end
                  end
               end
               default:
               begin
                  if (tick_cnt == 4'd15)
                  begin
                     rx_valid <= rx_sync;
                     state    <= RX_IDLE;
                  end
               end
            endcase
         end
      end
   end

   // lsb arrives first
   always_ff @(posedge clk)
   begin
      if (sample_tick && state == RX_DATA && tick_cnt == 4'd15)
      begin
         rx_shift <= {rx_sync, rx_shift[7:1]};
      end
   end

   a_valid_pulse: assert property (@(posedge clk) disable iff (reset)
      rx_valid |=> !rx_valid);

endmodule

// File: src/dl11_regs.sv
//====================
// DL11 register block on the I/O page
// decodes RCSR, RBUF, XCSR and XBUF, runs the transmit and receive handshakes
// and raises one registered interrupt with receive before transmit
//====================
`timescale 1ns/10ps
`include "dl11_macros.svh"

module dl11_regs
(
   input  logic                  clk,
   input  logic                  reset,
   input  dl11_pkg::iopage_req_t req,
   output logic [15:0]           rdata,
   output logic                  decode,
   output logic                  tx_load,
   output logic [7:0]            tx_data,
   input  logic                  tx_empty,
   input  dl11_pkg::rx_char_t    rx_char,
   output dl11_pkg::intr_t       intr
);

   import dl11_pkg::*;

   typedef enum logic [1:0]
   {
      TX_IDLE,
      TX_LOADING,
      TX_SENDING
   } tx_state_t;

   typedef enum logic
   {
      RX_IDLE,
      RX_DONE
   } rx_state_t;

   tx_state_t   tx_state;
   rx_state_t   rx_state;
   logic        rx_ie;
   logic        tx_ie;
   logic [15:0] xbuf;
   logic [7:0]  rbuf;
   logic        tx_ready;
   logic        rx_done;
   logic        xbuf_wr;
   logic        rbuf_rd;
   logic [15:0] rcsr_val;
   logic [15:0] xcsr_val;
   logic        rx_int;
   logic        tx_int;
   intr_t       intr_next;

   assign decode = (req.addr == `DL11_RCSR_ADDR) || (req.addr == `DL11_RBUF_ADDR) ||
                   (req.addr == `DL11_XCSR_ADDR) || (req.addr == `DL11_XBUF_ADDR);

   assign xbuf_wr  = req.wr && (req.addr == `DL11_XBUF_ADDR);
   assign rbuf_rd  = req.rd && (req.addr == `DL11_RBUF_ADDR);
   assign tx_ready = (tx_state == TX_IDLE);
   assign rx_done  = (rx_state == RX_DONE);
   assign tx_load  = (tx_state == TX_LOADING);
   assign tx_data  = xbuf[7:0];

   always_comb
   begin
      rcsr_val = '0;
      rcsr_val[`DL11_DONE_BIT] = rx_done;
      rcsr_val[`DL11_IE_BIT]   = rx_ie;
      xcsr_val = '0;
      xcsr_val[`DL11_DONE_BIT] = tx_ready;
      xcsr_val[`DL11_IE_BIT]   = tx_ie;
   end

   always_comb
   begin
      rdata = '0;
      if (req.rd)
      begin
         case (req.addr)
            `DL11_RCSR_ADDR: rdata = rcsr_val;
            `DL11_RBUF_ADDR: rdata = {8'h00, rbuf};
            `DL11_XCSR_ADDR: rdata = xcsr_val;
            `DL11_XBUF_ADDR: rdata = xbuf;
            default:         rdata = '0;
         endcase
      end
   end

   // interrupt enables
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rx_ie <= 1'b0;
         tx_ie <= 1'b0;
      end
      else if (req.wr)
      begin
         if (req.addr == `DL11_RCSR_ADDR)
         begin
            rx_ie <= req.wdata[`DL11_IE_BIT];
         end
         if (req.addr == `DL11_XCSR_ADDR)
         begin
            tx_ie <= req.wdata[`DL11_IE_BIT];
         end
      end
   end

   // XBUF always takes the write, even while a character is in flight
   always_ff @(posedge clk)
   begin
      if (xbuf_wr)
      begin
         xbuf <= req.wdata;
      end
      if (rx_char.valid)
      begin
         rbuf <= rx_char.data;
      end
   end

   // hold tx_load until the uart goes busy, then wait for it to drain
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         tx_state <= TX_IDLE;
      end
      else
      begin
         case (tx_state)
            TX_IDLE:    if (xbuf_wr) tx_state <= TX_LOADING;
            TX_LOADING: if (!tx_empty) tx_state <= TX_SENDING;
            TX_SENDING: if (tx_empty) tx_state <= TX_IDLE;
            default:    tx_state <= TX_IDLE;
         endcase
      end
   end

   // a new character wins over a read in the same cycle
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rx_state <= RX_IDLE;
      end
      else if (rx_char.valid)
      begin
         rx_state <= RX_DONE;
      end
      else if (rx_done && rbuf_rd)
      begin
         rx_state <= RX_IDLE;
      end
   end

   assign rx_int = rx_ie && rx_done;
   assign tx_int = tx_ie && tx_ready;

   always_comb
   begin
      intr_next.req    = rx_int || tx_int;
      intr_next.vector = rx_int ? `DL11_RX_VECTOR :
                         tx_int ? `DL11_TX_VECTOR : 8'h00;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         intr <= '0;
      end
      else
      begin
         intr <= intr_next;
      end
   end

   // ready must mean the transmitter is idle when a load starts
   a_load_when_empty: assert property (@(posedge clk) disable iff (reset)
      $rose(tx_load) |-> tx_empty);

   a_req_vector: assert property (@(posedge clk) disable iff (reset)
      intr.req |-> intr.vector != 8'h00);

endmodule

// File: src/dl11_console.sv
//====================
// DL11 console serial line, top level
// CPU bus and interrupt on one side, tx and rx serial pins on the other
//====================
`timescale 1ns/10ps

module dl11_console
(
   input  logic                  clk,
   input  logic                  reset,
   input  dl11_pkg::iopage_req_t req,
   output logic [15:0]           rdata,
   output logic                  decode,
   output dl11_pkg::intr_t       intr,
   output logic                  tx,
   input  logic                  rx
);

   import dl11_pkg::*;

   logic       sample_tick;
   logic       bit_tick;
   logic       tx_load;
   logic [7:0] tx_data;
   logic       tx_empty;
   rx_char_t   rx_char;

   dl11_baud_gen u_baud_gen
   (
      .clk         (clk),
      .reset       (reset),
      .sample_tick (sample_tick),
      .bit_tick    (bit_tick)
   );

   dl11_uart_tx u_uart_tx
   (
      .clk      (clk),
      .reset    (reset),
      .bit_tick (bit_tick),
      .tx_load  (tx_load),
      .tx_data  (tx_data),
      .tx       (tx),
      .tx_empty (tx_empty)
   );

   dl11_uart_rx u_uart_rx
   (
      .clk         (clk),
      .reset       (reset),
      .sample_tick (sample_tick),
      .rx          (rx),
      .rx_char     (rx_char)
   );

   dl11_regs u_regs
   (
      .clk      (clk),
      .reset    (reset),
      .req      (req),
      .rdata    (rdata),
      .decode   (decode),
      .tx_load  (tx_load),
      .tx_data  (tx_data),
      .tx_empty (tx_empty),
      .rx_char  (rx_char),
      .intr     (intr)
   );

endmodule

// File: dv/dl11_tb_serial.sv
//====================
// serial line model for the DL11 testbench
// sends characters on rx and checks the frames captured from tx
//====================
`timescale 1ns/10ps
`include "dl11_macros.svh"

module dl11_tb_serial
(
   input  logic       clk,
   input  logic       reset,
   input  logic       tx,
   output logic       rx,
   input  logic [7:0] send_byte,
   input  logic       send_go,
   output logic       rx_busy,
   input  logic [7:0] exp_tx_byte,
   output int         frame_cnt,
   output int         err_cnt
);

   localparam int BIT_CLKS = 16 * `DL11_BAUD_DIV;

   logic       frame_done;
   logic       cap_start;
   logic [7:0] cap_byte;
   logic       cap_stop;
   int         errs = 0;

   assign err_cnt = errs;

   // 8N1 sender toward the DUT rx pin, lsb first
   initial
   begin
      rx      <= 1'b1;
      rx_busy <= 1'b0;
      forever
      begin
         @(posedge clk);
         if (send_go)
         begin
            rx_busy <= 1'b1;
            rx      <= 1'b0;
            repeat (BIT_CLKS) @(posedge clk);
            for (int i = 0; i < 8; i++)
            begin
               rx <= send_byte[i];
               repeat (BIT_CLKS) @(posedge clk);
            end
            rx <= 1'b1;
            repeat (BIT_CLKS) @(posedge clk);
            rx_busy <= 1'b0;
         end
      end
   end

   // frame capture on tx, sampled near mid-bit on the falling clock
   initial
   begin
      frame_cnt  <= 0;
      frame_done <= 1'b0;
      cap_start = 1'b1;
      cap_byte  = '0;
      cap_stop  = 1'b1;
      @(negedge reset);
      forever
      begin
         @(negedge clk);
         if (!tx)
         begin
            repeat (BIT_CLKS / 2 - 1) @(negedge clk);
            cap_start = tx;
            for (int i = 0; i < 8; i++)
            begin
               repeat (BIT_CLKS) @(negedge clk);
               cap_byte[i] = tx;
            end
            repeat (BIT_CLKS) @(negedge clk);
            cap_stop = tx;
            frame_cnt  <= frame_cnt + 1;
            frame_done <= 1'b1;
            @(negedge clk);
            frame_done <= 1'b0;
         end
      end
   end

   a_tx_start: assert property (@(posedge clk) disable iff (reset)
      frame_done |-> cap_start == 1'b0)
   else
   begin
      errs = errs + 1;
      $display("[ERROR] tx start bit got %h exp %h", $sampled(cap_start), 1'b0);
   end

   a_tx_data: assert property (@(posedge clk) disable iff (reset)
      frame_done |-> cap_byte == exp_tx_byte)
   else
   begin
      errs = errs + 1;
      $display("[ERROR] tx data got %h exp %h", $sampled(cap_byte), $sampled(exp_tx_byte));
   end

   a_tx_stop: assert property (@(posedge clk) disable iff (reset)
      frame_done |-> cap_stop == 1'b1)
   else
   begin
      errs = errs + 1;
      $display("[ERROR] tx stop bit got %h exp %h", $sampled(cap_stop), 1'b1);
   end

endmodule

// File: dv/dl11_tb.sv
//====================
// testbench for the DL11 console
// bus tasks and a serial line model drive the DUT, assertions do the checks
//====================
`timescale 1ns/10ps
`include "dl11_macros.svh"

module dl11_tb;

   import dl11_pkg::*;

   localparam int BIT_CLKS   = 16 * `DL11_BAUD_DIV;
   localparam int FRAME_CLKS = 10 * BIT_CLKS;
   // seven frames go over the line, eight are allowed plus slack for bus traffic
   localparam int TIMEOUT_CLKS = 8 * FRAME_CLKS + 2000;
   localparam int NUM_CHARS    = 3;
   localparam iopage_req_t IDLE_REQ = '0;

   logic        clk;
   logic        reset;
   iopage_req_t req;
   logic [15:0] rdata;
   logic        decode;
   intr_t       intr;
   logic        tx;
   logic        rx;

   // expected values and enables for the checkers
   logic        chk_rd;
   logic [15:0] exp_rdata;
   logic        chk_xcsr;
   logic        chk_dec;
   logic        exp_decode;
   logic        chk_intr;
   intr_t       exp_intr;
   logic        chk_idle;
   int          frames_sent;
   logic [7:0]  exp_tx_byte;
   logic [7:0]  send_byte;
   logic        send_go;
   logic        rx_busy;
   int          frame_cnt;
   int          serial_errors;
   int          errors = 0;
   integer      seed = 32'hba58;

   dl11_console u_dl11_console
   (
      .clk    (clk),
      .reset  (reset),
      .req    (req),
      .rdata  (rdata),
      .decode (decode),
      .intr   (intr),
      .tx     (tx),
      .rx     (rx)
   );

   dl11_tb_serial u_serial
   (
      .clk         (clk),
      .reset       (reset),
      .tx          (tx),
      .rx          (rx),
      .send_byte   (send_byte),
      .send_go     (send_go),
      .rx_busy     (rx_busy),
      .exp_tx_byte (exp_tx_byte),
      .frame_cnt   (frame_cnt),
      .err_cnt     (serial_errors)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial
   begin
      repeat (TIMEOUT_CLKS) @(posedge clk);
      $display("timeout after %0d clocks, the stimulus did not finish", TIMEOUT_CLKS);
      $display("Finished with errors");
      $finish;
   end

   task automatic bus_write(input logic [12:0] addr, input logic [15:0] data);
      @(posedge clk);
      req <= {addr, data, 1'b0, 1'b1};
      @(posedge clk);
      req <= IDLE_REQ;
   endtask

   // rdata is combinational, so it is taken at mid-cycle
   task automatic bus_read(input logic [12:0] addr, input logic check,
                           input logic [15:0] exp, output logic [15:0] data);
      @(posedge clk);
      req       <= {addr, 16'h0000, 1'b1, 1'b0};
      chk_rd    <= check;
      exp_rdata <= exp;
      chk_xcsr  <= (addr == `DL11_XCSR_ADDR);
      @(negedge clk);
      data = rdata;
      @(posedge clk);
      req      <= IDLE_REQ;
      chk_rd   <= 1'b0;
      chk_xcsr <= 1'b0;
   endtask

   task automatic wait_status_set(input logic [12:0] addr);
      logic [15:0] d;
      d = '0;
      while (!d[`DL11_DONE_BIT])
      begin
         bus_read(addr, 1'b0, 16'h0000, d);
      end
   endtask

   task automatic check_decode(input logic [12:0] addr, input logic exp);
      @(posedge clk);
      req        <= {addr, 16'hffff, 1'b0, 1'b0};
      exp_decode <= exp;
      chk_dec    <= 1'b1;
      @(posedge clk);
      req     <= IDLE_REQ;
      chk_dec <= 1'b0;
   endtask

   task automatic check_intr(input logic exp_req, input logic [7:0] exp_vec);
      // intr is registered, give it time to follow the request
      repeat (2) @(posedge clk);
      chk_intr <= 1'b1;
      exp_intr <= {exp_req, exp_vec};
      @(posedge clk);
      chk_intr <= 1'b0;
   endtask

   task automatic send_char(input logic [7:0] b);
      while (rx_busy)
      begin
         @(posedge clk);
      end
      @(posedge clk);
      send_byte <= b;
      send_go   <= 1'b1;
      @(posedge clk);
      send_go <= 1'b0;
   endtask

   a_rdata: assert property (@(posedge clk) disable iff (reset)
      chk_rd |-> rdata == exp_rdata)
   else
   begin
      errors = errors + 1;
      $display("[ERROR] rdata at addr %h got %h exp %h", $sampled(req.addr),
               $sampled(rdata), $sampled(exp_rdata));
   end

   a_rdata_zero: assert property (@(posedge clk) disable iff (reset)
      (!req.rd || !decode) |-> rdata == 16'h0000)
   else
   begin
      errors = errors + 1;
      $display("[ERROR] rdata with no decoded read got %h exp %h", $sampled(rdata), 16'h0000);
   end

   a_decode: assert property (@(posedge clk) disable iff (reset)
      chk_dec |-> decode == exp_decode)
   else
   begin
      errors = errors + 1;
      $display("[ERROR] decode at addr %h got %h exp %h", $sampled(req.addr),
               $sampled(decode), $sampled(exp_decode));
   end

   a_ready_after_frame: assert property (@(posedge clk) disable iff (reset)
      (chk_xcsr && rdata[`DL11_DONE_BIT]) |-> frame_cnt == frames_sent)
   else
   begin
      errors = errors + 1;
      $display("XCSR ready was set before the transmitted frame was complete");
   end

   a_intr: assert property (@(posedge clk) disable iff (reset)
      chk_intr |-> intr == exp_intr)
   else
   begin
      errors = errors + 1;
      $display("[ERROR] intr req got %h exp %h, vector got %h exp %h", $sampled(intr.req),
               $sampled(exp_intr.req), $sampled(intr.vector), $sampled(exp_intr.vector));
   end

   a_idle: assert property (@(posedge clk) disable iff (reset)
      chk_idle |-> tx && !intr.req)
   else
   begin
      errors = errors + 1;
      $display("[ERROR] after reset tx got %h exp 1, intr.req got %h exp 0",
               $sampled(tx), $sampled(intr.req));
   end

   initial
   begin
      logic [15:0] d;
      logic [31:0] rnd;
      logic [15:0] word;
      logic [7:0]  b;
      reset       <= 1'b1;
      req         <= IDLE_REQ;
      chk_rd      <= 1'b0;
      exp_rdata   <= '0;
      chk_xcsr    <= 1'b0;
      chk_dec     <= 1'b0;
      exp_decode  <= 1'b0;
      chk_intr    <= 1'b0;
      exp_intr    <= '0;
      chk_idle    <= 1'b0;
      frames_sent <= 0;
      exp_tx_byte <= '0;
      send_byte   <= '0;
      send_go     <= 1'b0;
      repeat (5) @(posedge clk);
      reset <= 1'b0;

      // reset state
      chk_idle <= 1'b1;
      bus_read(`DL11_RCSR_ADDR, 1'b1, 16'h0000, d);
      bus_read(`DL11_XCSR_ADDR, 1'b1, 16'o200, d);
      check_intr(1'b0, 8'h00);
      chk_idle <= 1'b0;

      // address decode, the four registers and their neighbours
      check_decode(`DL11_RCSR_ADDR, 1'b1);
      check_decode(`DL11_RBUF_ADDR, 1'b1);
      check_decode(`DL11_XCSR_ADDR, 1'b1);
      check_decode(`DL11_XBUF_ADDR, 1'b1);
      check_decode(`DL11_RCSR_ADDR - 13'd2, 1'b0);
      check_decode(`DL11_XBUF_ADDR + 13'd2, 1'b0);
      check_decode(`DL11_RCSR_ADDR + 13'd1, 1'b0);
      bus_read(`DL11_XBUF_ADDR + 13'd2, 1'b1, 16'h0000, d);

      // transmit random words, the line carries the low byte
      for (int i = 0; i < NUM_CHARS; i++)
      begin
         rnd = $random(seed);
         word = rnd[15:0];
         exp_tx_byte <= word[7:0];
         frames_sent <= frames_sent + 1;
         bus_write(`DL11_XBUF_ADDR, word);
         bus_read(`DL11_XCSR_ADDR, 1'b1, 16'h0000, d);
         wait_status_set(`DL11_XCSR_ADDR);
         bus_read(`DL11_XBUF_ADDR, 1'b1, word, d);
      end

      // receive random bytes, one RBUF read clears done
      for (int i = 0; i < NUM_CHARS; i++)
      begin
         rnd = $random(seed);
         b = rnd[7:0];
         send_char(b);
         wait_status_set(`DL11_RCSR_ADDR);
         bus_read(`DL11_RBUF_ADDR, 1'b1, {8'h00, b}, d);
         bus_read(`DL11_RCSR_ADDR, 1'b1, 16'h0000, d);
      end

      // transmit alone, then receive over transmit, then both enables clear
      bus_write(`DL11_XCSR_ADDR, 16'o100);
      check_intr(1'b1, `DL11_TX_VECTOR);
      rnd = $random(seed);
      b = rnd[7:0];
      send_char(b);
      wait_status_set(`DL11_RCSR_ADDR);
      bus_write(`DL11_RCSR_ADDR, 16'o100);
      check_intr(1'b1, `DL11_RX_VECTOR);
      bus_read(`DL11_RCSR_ADDR, 1'b1, 16'o300, d);
      bus_read(`DL11_XCSR_ADDR, 1'b1, 16'o300, d);
      bus_write(`DL11_RCSR_ADDR, 16'h0000);
      bus_write(`DL11_XCSR_ADDR, 16'h0000);
      check_intr(1'b0, 8'h00);
      bus_read(`DL11_RBUF_ADDR, 1'b1, {8'h00, b}, d);
      bus_read(`DL11_RCSR_ADDR, 1'b1, 16'h0000, d);

      repeat (4) @(posedge clk);
      $display("checks complete: %0d testbench errors, %0d serial model errors",
               errors, serial_errors);
      if (errors + serial_errors == 0)
      begin
         $display("Finished with no errors");
      end
      else
      begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// File: build.f
+incdir+src
src/dl11_pkg.sv
src/dl11_baud_gen.sv
src/dl11_uart_tx.sv
src/dl11_uart_rx.sv
src/dl11_regs.sv
src/dl11_console.sv
dv/dl11_tb_serial.sv
dv/dl11_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the DL11 console testbench with Verilator
# exits nonzero unless the log holds the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ" "$LOG"

verilator --binary --timing --assert --timescale 1ns/10ps \
   --top-module dl11_tb --Mdir "$OBJ" -o dl11_sim -f build.f
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

"./$OBJ/dl11_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
   echo "PASS"
   exit 0
fi
echo "FAIL"
exit 1
